/* all.f */
hw/lane_pkg.sv
hw/lane_sequencer.sv
hw/operand_requester.sv
hw/vector_regfile.sv
hw/lane_alu.sv
hw/store_queue.sv
hw/lane.sv
bench/lane_properties.sv
bench/tb_lane.sv

/* bench/lane_properties.sv */
// Lane handshake properties
`timescale 1ns/10ps
`default_nettype none

module lane_properties import lane_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  pe_req_valid_i,
  input logic  pe_req_ready_i,
  input logic  insn_done_i,
  input logic  ldu_req_i,
  input logic  ldu_gnt_i,
  input elen_t stu_operand_i,
  input logic  stu_operand_valid_i,
  input logic  stu_operand_ready_i
);

  // One instruction outstanding between acceptance and its completion
  logic busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (pe_req_valid_i && pe_req_ready_i) begin
      busy_q <= 1'b1;
    end else if (insn_done_i) begin
      busy_q <= 1'b0;
    end
  end

  stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stu_operand_valid_i && !stu_operand_ready_i |=> stu_operand_valid_i && $stable(stu_operand_i))
    else $error("store operand changed while the store port was stalled");

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldu_gnt_i |-> ldu_req_i)
    else $error("load grant without a load request");

  busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_q && !insn_done_i |-> !pe_req_ready_i)
    else $error("lane ready while an instruction is still in flight");

endmodule

bind lane lane_properties i_lane_properties (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .pe_req_valid_i      (pe_req_valid_i),
  .pe_req_ready_i      (pe_req_ready_o),
  .insn_done_i         (insn_done_o),
  .ldu_req_i           (ldu_req_i),
  .ldu_gnt_i           (ldu_gnt_o),
  .stu_operand_i       (stu_operand_o),
  .stu_operand_valid_i (stu_operand_valid_o),
  .stu_operand_ready_i (stu_operand_ready_i)
);

`default_nettype wire

/* bench/tb_lane.sv */
// Vector lane testbench
`timescale 1ns/10ps
`default_nettype none

module tb_lane import lane_pkg::*; ();

  // Six tests come to about 1600 cycles, random stalls can double the store runs
  localparam int unsigned TimeoutCycles = 4000;

  logic       clk_i;
  logic       rst_ni;
  pe_req_t    pe_req_i;
  logic       pe_req_valid_i;
  logic       pe_req_ready_o;
  logic       insn_done_o;
  vid_t       insn_done_id_o;
  logic       ldu_req_i;
  vrf_write_t ldu_write_i;
  logic       ldu_gnt_o;
  elen_t      stu_operand_o;
  logic       stu_operand_valid_o;
  logic       stu_operand_ready_i;

  // Reference state
  elen_t       shadow [NrVrfWords];
  elen_t       store_q [$];
  vid_t        id_q [$];
  vid_t        next_id;
  logic [31:0] rnd_q;
  logic [31:0] stall_q = 32'ha21e;
  logic        stall_en;
  string       test_name;
  int unsigned cycles = 0;
  int unsigned issued = 0;
  int unsigned done_count = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned tests = 0;
  int unsigned test_start_errors = 0;

  lane lane_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pe_req_i            (pe_req_i),
    .pe_req_valid_i      (pe_req_valid_i),
    .pe_req_ready_o      (pe_req_ready_o),
    .insn_done_o         (insn_done_o),
    .insn_done_id_o      (insn_done_id_o),
    .ldu_req_i           (ldu_req_i),
    .ldu_write_i         (ldu_write_i),
    .ldu_gnt_o           (ldu_gnt_o),
    .stu_operand_o       (stu_operand_o),
    .stu_operand_valid_o (stu_operand_valid_o),
    .stu_operand_ready_i (stu_operand_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic vaddr_t vrf_addr(vreg_t r, int i);
    return {r, elem_idx_t'(i)};
  endfunction

  task automatic compare_value(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_failure(string what);
    $display("Error in %s: %s", test_name, what);
    errors++;
  endtask

  // Fill one register from the load port while the lane is idle
  task automatic load_reg(vreg_t r);
    vrf_write_t w;
    for (int i = 0; i < int'(ElemsPerVReg); i++) begin
      rnd_q = xorshift(rnd_q);
      w.addr = vrf_addr(r, i);
      w.data = rnd_q;
      @(posedge clk_i);
      ldu_req_i   <= 1'b1;
      ldu_write_i <= w;
      @(negedge clk_i);
      while (!ldu_gnt_o) begin
        @(negedge clk_i);
      end
      shadow[w.addr] = w.data;
    end
    @(posedge clk_i);
    ldu_req_i <= 1'b0;
  endtask

  task automatic issue_insn(lane_op_e op, vreg_t vs1, vreg_t vs2, vreg_t vd, vlen_t vl);
    pe_req_t req;
    elen_t   a;
    elen_t   b;
    req = '{id: next_id, op: op, vs1: vs1, vs2: vs2, vd: vd, vl: vl};
    @(posedge clk_i);
    pe_req_i       <= req;
    pe_req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!pe_req_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    pe_req_valid_i <= 1'b0;
    id_q.push_back(next_id);
    next_id = next_id + vid_t'(1);
    issued++;
    // Element i reads only element i of its sources, so updating in place is safe
    for (int i = 0; i < int'(vl); i++) begin
      a = shadow[vrf_addr(vs1, i)];
      b = shadow[vrf_addr(vs2, i)];
      case (op)
        VADD:    shadow[vrf_addr(vd, i)] = b + a;
        VSUB:    shadow[vrf_addr(vd, i)] = b - a;
        VAND:    shadow[vrf_addr(vd, i)] = b & a;
        VOR:     shadow[vrf_addr(vd, i)] = b | a;
        VXOR:    shadow[vrf_addr(vd, i)] = b ^ a;
        default: store_q.push_back(b);
      endcase
    end
    while (done_count < issued) begin
      @(posedge clk_i);
    end
  endtask

  task automatic end_test();
    int unsigned n;
    while (store_q.size() != 0) begin
      @(posedge clk_i);
    end
    n = errors - test_start_errors;
    tests++;
    if (n == 0) begin
      $display("%-16s ok", test_name);
    end else begin
      $display("%-16s %0d errors", test_name, n);
    end
    test_start_errors = errors;
  endtask

  ////////////////////////////////////////
  // Monitors, stalls and timeout
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni && stu_operand_valid_o && stu_operand_ready_i) begin
      assert (store_q.size() != 0) else begin
        report_failure("store port emitted an element that no store asked for");
      end
      if (store_q.size() != 0) begin
        compare_value("store element", store_q.pop_front(), stu_operand_o);
      end
    end
    if (rst_ni && insn_done_o) begin
      done_count++;
      assert (id_q.size() != 0) else begin
        report_failure("completion pulse without an outstanding instruction");
      end
      if (id_q.size() != 0) begin
        compare_value("completion id", 32'(id_q.pop_front()), 32'(insn_done_id_o));
      end
    end
  end

  always @(posedge clk_i) begin
    stall_q             <= xorshift(stall_q);
    stu_operand_ready_i <= !stall_en || stall_q[7];
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == TimeoutCycles) begin
      $display("Timeout after %0d cycles in %s, the lane stopped responding", cycles, test_name);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin
    vlen_t    vl_a;
    vlen_t    vl_b;
    lane_op_e op;
    rst_ni              = 1'b0;
    pe_req_i            = '0;
    pe_req_valid_i      = 1'b0;
    ldu_req_i           = 1'b0;
    ldu_write_i         = '0;
    stu_operand_ready_i = 1'b1;
    stall_en            = 1'b0;
    next_id             = '0;
    rnd_q               = 32'ha21e;
    test_name           = "reset_state";
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(negedge clk_i);
    compare_value("pe_req_ready_o", 32'd1, 32'(pe_req_ready_o));
    compare_value("insn_done_o", 32'd0, 32'(insn_done_o));
    compare_value("stu_operand_valid_o", 32'd0, 32'(stu_operand_valid_o));
    compare_value("ldu_gnt_o", 32'd0, 32'(ldu_gnt_o));
    end_test();

    // Every register gets defined contents before any ALU use
    test_name = "load_store";
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      load_reg(vreg_t'(r));
    end
    for (int k = 0; k < 8; k++) begin
      rnd_q = xorshift(rnd_q);
      issue_insn(VSTORE, '0, rnd_q[4:0], '0, vlen_t'(ElemsPerVReg));
    end
    end_test();

    test_name = "alu_ops";
    for (int k = 0; k < 10; k++) begin
      rnd_q = xorshift(rnd_q);
      issue_insn(lane_op_e'(k % 5), rnd_q[4:0], rnd_q[9:5], rnd_q[14:10],
                 vlen_t'(ElemsPerVReg));
      issue_insn(VSTORE, '0, rnd_q[14:10], '0, vlen_t'(ElemsPerVReg));
    end
    end_test();

    // First round uses vl of 0 on both instructions
    test_name = "partial_vl";
    for (int k = 0; k < 8; k++) begin
      rnd_q = xorshift(rnd_q);
      vl_a  = (k == 0) ? '0 : vlen_t'(rnd_q[23:16] % 9);
      vl_b  = (k == 0) ? '0 : vlen_t'(rnd_q[31:24] % 9);
      issue_insn(lane_op_e'(k % 5), rnd_q[4:0], rnd_q[9:5], rnd_q[14:10], vl_a);
      // Full read of vd shows the tail left alone
      issue_insn(VSTORE, '0, rnd_q[14:10], '0, vlen_t'(ElemsPerVReg));
      issue_insn(VSTORE, '0, rnd_q[9:5], '0, vl_b);
    end
    end_test();

    test_name = "store_stall";
    stall_en <= 1'b1;
    for (int k = 0; k < 12; k++) begin
      rnd_q = xorshift(rnd_q);
      issue_insn(VSTORE, '0, rnd_q[4:0], '0, vlen_t'(ElemsPerVReg));
    end
    end_test();

    test_name = "completion_ids";
    for (int k = 0; k < 20; k++) begin
      rnd_q = xorshift(rnd_q);
      op    = lane_op_e'(rnd_q[31:24] % 6);
      vl_a  = vlen_t'(rnd_q[23:16] % 9);
      issue_insn(op, rnd_q[4:0], rnd_q[9:5], rnd_q[14:10], vl_a);
    end
    // Idle window in which no further completion may show up
    repeat (4) @(posedge clk_i);
    compare_value("completion count", issued, done_count);
    compare_value("pending ids", 32'd0, 32'(id_q.size()));
    stall_en <= 1'b0;
    end_test();

    $display("Tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/lane.sv */
// Vector lane top level
`timescale 1ns/10ps
`default_nettype none

module lane import lane_pkg::*; #(
  parameter int unsigned StoreQueueDepth = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Instruction requests
  input  pe_req_t    pe_req_i,
  input  logic       pe_req_valid_i,
  output logic       pe_req_ready_o,
  output logic       insn_done_o,
  output vid_t       insn_done_id_o,
  // Load unit writes
  input  logic       ldu_req_i,
  input  vrf_write_t ldu_write_i,
  output logic       ldu_gnt_o,
  // Store unit operands
  output elen_t      stu_operand_o,
  output logic       stu_operand_valid_o,
  input  logic       stu_operand_ready_i
);

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  pe_req_t cmd;
  logic    cmd_valid;
  logic    cmd_ready;
  logic    retire;

  lane_sequencer i_lane_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .cmd_o          (cmd),
    .cmd_valid_o    (cmd_valid),
    .cmd_ready_i    (cmd_ready),
    .retire_i       (retire),
    .insn_done_o    (insn_done_o),
    .insn_done_id_o (insn_done_id_o)
  );

  ////////////////////////////////////////
  // Operand requester
  ////////////////////////////////////////

  logic       rd_en;
  vaddr_t     rd_addr_a;
  vaddr_t     rd_addr_b;
  logic       wr_en;
  vrf_write_t vrf_wr;
  alu_cmd_t   alu_cmd;
  logic       alu_cmd_valid;
  vrf_write_t alu_wr;
  logic       alu_wr_valid;
  logic       alu_last;
  logic       stq_push;
  logic       stq_credit;

  operand_requester #(
    .StoreQueueDepth (StoreQueueDepth)
  ) i_operand_requester (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_i           (cmd),
    .cmd_valid_i     (cmd_valid),
    .cmd_ready_o     (cmd_ready),
    .retire_o        (retire),
    .rd_en_o         (rd_en),
    .rd_addr_a_o     (rd_addr_a),
    .rd_addr_b_o     (rd_addr_b),
    .wr_en_o         (wr_en),
    .wr_o            (vrf_wr),
    .alu_cmd_o       (alu_cmd),
    .alu_cmd_valid_o (alu_cmd_valid),
    .alu_wr_i        (alu_wr),
    .alu_wr_valid_i  (alu_wr_valid),
    .alu_last_i      (alu_last),
    .stq_push_o      (stq_push),
    .stq_credit_i    (stq_credit),
    .ldu_req_i       (ldu_req_i),
    .ldu_write_i     (ldu_write_i),
    .ldu_gnt_o       (ldu_gnt_o)
  );

  ////////////////////////////////////////
  // VRF, ALU and store queue
  ////////////////////////////////////////

  elen_t rd_data_a;
  elen_t rd_data_b;

  vector_regfile i_vrf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_en_i     (rd_en),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b),
    .wr_en_i     (wr_en),
    .wr_i        (vrf_wr)
  );

  lane_alu i_lane_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (alu_cmd),
    .cmd_valid_i (alu_cmd_valid),
    .op_a_i      (rd_data_a),
    .op_b_i      (rd_data_b),
    .wr_o        (alu_wr),
    .wr_valid_o  (alu_wr_valid),
    .last_o      (alu_last)
  );

  // Stores read their register through port B
  store_queue #(
    .StoreQueueDepth (StoreQueueDepth)
  ) i_store_queue (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .push_i              (stq_push),
    .data_i              (rd_data_b),
    .stu_operand_o       (stu_operand_o),
    .stu_operand_valid_o (stu_operand_valid_o),
    .stu_operand_ready_i (stu_operand_ready_i),
    .credit_o            (stq_credit)
  );

endmodule

`default_nettype wire

/* hw/lane_alu.sv */
// Integer lane ALU
`timescale 1ns/10ps
`default_nettype none

module lane_alu import lane_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  alu_cmd_t   cmd_i,
  input  logic       cmd_valid_i,
  // Operand A is vs1, operand B is vs2
  input  elen_t      op_a_i,
  input  elen_t      op_b_i,
  output vrf_write_t wr_o,
  output logic       wr_valid_o,
  output logic       last_o
);

  elen_t      result;
  vrf_write_t wr_q;
  logic       wr_valid_q;
  logic       last_q;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_comb begin
    result = '0;
    case (cmd_i.op)
      VADD:    result = op_b_i + op_a_i;
      VSUB:    result = op_b_i - op_a_i;
      VAND:    result = op_b_i & op_a_i;
      VOR:     result = op_b_i | op_a_i;
      VXOR:    result = op_b_i ^ op_a_i;
      default: result = '0;
    endcase
  end

  ////////////////////////////////////////
  // Writeback stage
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_valid_q <= 1'b0;
      last_q     <= 1'b0;
    end else begin
      wr_valid_q <= cmd_valid_i;
      last_q     <= cmd_valid_i && cmd_i.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      wr_q.addr <= cmd_i.addr;
      wr_q.data <= result;
    end
  end

  assign wr_o       = wr_q;
  assign wr_valid_o = wr_valid_q;
  assign last_o     = last_q;

endmodule

`default_nettype wire

/* hw/lane_pkg.sv */
// Vector lane shared definitions
`default_nettype none

package lane_pkg;

  ////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////

  localparam int unsigned ElemsPerVReg = 8;
  localparam int unsigned NrVRegs      = 32;

  // One VRF word per element of every register
  localparam int unsigned NrVrfWords   = NrVRegs * ElemsPerVReg;

  ////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////

  typedef logic [31:0] elen_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  typedef logic [$clog2(ElemsPerVReg)-1:0] elem_idx_t;

  // Must also hold vl equal to ElemsPerVReg
  typedef logic [$clog2(ElemsPerVReg+1)-1:0] vlen_t;

  // Register number in the upper bits, element index below
  typedef logic [$bits(vreg_t)+$bits(elem_idx_t)-1:0] vaddr_t;

  typedef logic [1:0] vid_t;

  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VSTORE
  } lane_op_e;

  ////////////////////////////////////////
  // Request structs
  ////////////////////////////////////////

  // Instruction from the main sequencer
  typedef struct packed {
    vid_t     id;
    lane_op_e op;
    vreg_t    vs1;
    vreg_t    vs2;
    vreg_t    vd;
    vlen_t    vl;
  } pe_req_t;

  // VRF write, from the ALU or the load unit
  typedef struct packed {
    vaddr_t addr;
    elen_t  data;
  } vrf_write_t;

  // Per-element ALU command, aligned with the VRF read data
  typedef struct packed {
    lane_op_e op;
    vaddr_t   addr;
    logic     last;
  } alu_cmd_t;

endpackage

`default_nettype wire

/* hw/lane_sequencer.sv */
// Lane instruction sequencer
`timescale 1ns/10ps
`default_nettype none

module lane_sequencer import lane_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Main sequencer side
  input  pe_req_t pe_req_i,
  input  logic    pe_req_valid_i,
  output logic    pe_req_ready_o,
  // Operand requester side
  output pe_req_t cmd_o,
  output logic    cmd_valid_o,
  input  logic    cmd_ready_i,
  input  logic    retire_i,
  // Completion
  output logic    insn_done_o,
  output vid_t    insn_done_id_o
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT
  } state_e;

  state_e  state_q;
  state_e  state_d;
  pe_req_t req_q;
  logic    done_q;
  logic    done_d;
  logic    accept;

  assign pe_req_ready_o = (state_q == IDLE);
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  assign cmd_o       = req_q;
  assign cmd_valid_o = (state_q == ISSUE);

  // req_q keeps the id until a new request lands after the pulse
  assign insn_done_o    = done_q;
  assign insn_done_id_o = req_q.id;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        // A zero-length request retires in the handoff cycle
        if (cmd_ready_i) begin
          if (retire_i) begin
            state_d = IDLE;
            done_d  = 1'b1;
          end else begin
            state_d = WAIT;
          end
        end
      end
      WAIT: begin
        if (retire_i) begin
          state_d = IDLE;
          done_d  = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= pe_req_i;
    end
  end

endmodule

`default_nettype wire

/* hw/operand_requester.sv */
// Operand requester and VRF write arbiter
`timescale 1ns/10ps
`default_nettype none

module operand_requester import lane_pkg::*; #(
  parameter int unsigned StoreQueueDepth = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Lane sequencer
  input  pe_req_t    cmd_i,
  input  logic       cmd_valid_i,
  output logic       cmd_ready_o,
  output logic       retire_o,
  // VRF
  output logic       rd_en_o,
  output vaddr_t     rd_addr_a_o,
  output vaddr_t     rd_addr_b_o,
  output logic       wr_en_o,
  output vrf_write_t wr_o,
  // ALU
  output alu_cmd_t   alu_cmd_o,
  output logic       alu_cmd_valid_o,
  input  vrf_write_t alu_wr_i,
  input  logic       alu_wr_valid_i,
  input  logic       alu_last_i,
  // Store queue
  output logic       stq_push_o,
  input  logic       stq_credit_i,
  // Load unit
  input  logic       ldu_req_i,
  input  vrf_write_t ldu_write_i,
  output logic       ldu_gnt_o
);

  localparam int unsigned CreditW = $clog2(StoreQueueDepth + 1);

  typedef logic [CreditW-1:0] credit_t;

  pe_req_t   cmd_q;
  logic      busy_q;
  vlen_t     elem_q;
  elem_idx_t idx;
  logic      is_store;
  logic      issue;
  logic      issue_last;
  logic      accept;
  credit_t   credit_q;
  logic      issued_q;
  logic      last_q;
  lane_op_e  op_q;
  vaddr_t    dest_q;

  ////////////////////////////////////////
  // Element walker
  ////////////////////////////////////////

  assign cmd_ready_o = !busy_q;
  assign accept      = cmd_valid_i && cmd_ready_o;

  assign idx        = elem_q[$bits(elem_idx_t)-1:0];
  assign is_store   = (cmd_q.op == VSTORE);
  assign issue_last = (elem_q == cmd_q.vl - vlen_t'(1));

  // Stores wait for room in the store queue
  assign issue = busy_q && (!is_store || (credit_q != '0));

  assign rd_en_o     = issue;
  assign rd_addr_a_o = {cmd_q.vs1, idx};
  assign rd_addr_b_o = {cmd_q.vs2, idx};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      elem_q <= '0;
    end else if (accept) begin
      busy_q <= (cmd_i.vl != '0);
      elem_q <= '0;
    end else if (issue) begin
      elem_q <= elem_q + vlen_t'(1);
      if (issue_last) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q <= cmd_i;
    end
  end

  // Reads in flight plus queue entries never exceed the depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= credit_t'(StoreQueueDepth);
    end else begin
      credit_q <= credit_q - credit_t'(issue && is_store) + credit_t'(stq_credit_i);
    end
  end

  ////////////////////////////////////////
  // Read data alignment
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      issued_q <= issue;
      last_q   <= issue && issue_last;
    end
  end

  always_ff @(posedge clk_i) begin
    op_q   <= cmd_q.op;
    dest_q <= {cmd_q.vd, idx};
  end

  assign alu_cmd_valid_o = issued_q && (op_q != VSTORE);
  assign alu_cmd_o       = '{op: op_q, addr: dest_q, last: last_q};
  assign stq_push_o      = issued_q && (op_q == VSTORE);

  ////////////////////////////////////////
  // Write port and retire
  ////////////////////////////////////////

  // ALU writebacks cannot stall, loads take the leftover cycles
  assign wr_en_o   = alu_wr_valid_i || ldu_req_i;
  assign wr_o      = alu_wr_valid_i ? alu_wr_i : ldu_write_i;
  assign ldu_gnt_o = ldu_req_i && !alu_wr_valid_i;

  assign retire_o = (accept && (cmd_i.vl == '0))
                 || (alu_wr_valid_i && alu_last_i)
                 || (stq_push_o && last_q);

endmodule

`default_nettype wire

/* hw/store_queue.sv */
// Store operand queue
`timescale 1ns/10ps
`default_nettype none

module store_queue import lane_pkg::*; #(
  parameter int unsigned StoreQueueDepth = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  elen_t data_i,
  output elen_t stu_operand_o,
  output logic  stu_operand_valid_o,
  input  logic  stu_operand_ready_i,
  output logic  credit_o
);

  localparam int unsigned PtrW = $clog2(StoreQueueDepth);
  localparam int unsigned CntW = $clog2(StoreQueueDepth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  elen_t mem [StoreQueueDepth];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  count_q;
  logic  pop;

  assign stu_operand_valid_o = (count_q != '0);
  assign stu_operand_o       = mem[rd_ptr_q];
  assign pop                 = stu_operand_valid_o && stu_operand_ready_i;

  // One credit back to the requester per element leaving
  assign credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap by compare so any depth works
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(StoreQueueDepth - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(StoreQueueDepth - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      count_q <= count_q + cnt_t'(push_i) - cnt_t'(pop);
    end
  end

endmodule

`default_nettype wire

/* hw/vector_regfile.sv */
// Vector register file
`timescale 1ns/10ps
`default_nettype none

module vector_regfile import lane_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Read ports
  input  logic       rd_en_i,
  input  vaddr_t     rd_addr_a_i,
  input  vaddr_t     rd_addr_b_i,
  output elen_t      rd_data_a_o,
  output elen_t      rd_data_b_o,
  // Write port
  input  logic       wr_en_i,
  input  vrf_write_t wr_i
);

  elen_t mem [NrVrfWords];
  elen_t rd_data_a_q;
  elen_t rd_data_b_q;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_i.addr] <= wr_i.data;
    end
  end

  // Same-cycle write is not forwarded
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_a_q <= '0;
      rd_data_b_q <= '0;
    end else if (rd_en_i) begin
      rd_data_a_q <= mem[rd_addr_a_i];
      rd_data_b_q <= mem[rd_addr_b_i];
    end
  end

  assign rd_data_a_o = rd_data_a_q;
  assign rd_data_b_o = rd_data_b_q;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lane -f all.f -o sim_lane

./obj_dir/sim_lane | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
  exit 0
fi
exit 1
